// File: axil2apb/axil2apb_bridge.sv
/* One AXI4-Lite transfer in flight; a write needs awvalid and wvalid in the same cycle.
   The response waits in StResp until bready or rready, with all AXI readies low. */
`default_nettype none

module axil2apb_bridge #(
  parameter int AddrWidth = 16,
  parameter int DataWidth = 32
) (
  input  logic                     clk,
  input  logic                     rst_n,

  // AXI4-Lite slave
  input  logic [AddrWidth-1:0]     awaddr,
  input  amba_pkg::prot_t          awprot,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [DataWidth-1:0]     wdata,
  input  logic [DataWidth/8-1:0]   wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output amba_pkg::axi_resp_t      bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logic [AddrWidth-1:0]     araddr,
  input  amba_pkg::prot_t          arprot,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [DataWidth-1:0]     rdata,
  output amba_pkg::axi_resp_t      rresp,
  output logic                     rvalid,
  input  logic                     rready,

  // APB master
  output logic [AddrWidth-1:0]     paddr,
  output logic                     psel,
  output logic                     penable,
  output logic                     pwrite,
  output logic [DataWidth-1:0]     pwdata,
  output logic [DataWidth/8-1:0]   pstrb,
  output amba_pkg::prot_t          pprot,
  input  logic [DataWidth-1:0]     prdata,
  input  logic                     pready,
  input  logic                     pslverr
);

  import amba_pkg::*;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [DataWidth/8-1:0] strb_t;

  bridge_state_t state_q;
  bridge_state_t state_d;

  // Captured request
  addr_t addr_q;
  data_t wdata_q;
  strb_t strb_q;
  prot_t prot_q;
  logic  write_q;
  // Captured completion
  logic  slverr_q;

  logic write_req;
  logic read_req;
  logic write_grant;
  logic read_grant;
  logic any_grant;
  logic access_done;
  logic resp_taken;

  if (DataWidth % 8 != 0) begin : gen_bad_data_width
    $error("DataWidth must be a multiple of 8");
  end
  if (AxiProtWidth != ApbProtWidth) begin : gen_bad_prot_width
    $error("AXI and APB prot fields differ in width");
  end

  // ------------------------------
  // Decode: arbitrate and capture
  // ------------------------------
  // Requests only count while idle
  assign write_req = awvalid && wvalid && (state_q == StIdle);
  assign read_req  = arvalid && (state_q == StIdle);

  // Bit 1 is the write side
  rr_arbiter rr_arbiter_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .request ({write_req, read_req}),
    .grant   ({write_grant, read_grant})
  );

  assign any_grant = write_grant || read_grant;

  // Grant cycle is the AXI handshake
  assign awready = write_grant;
  assign wready  = write_grant;
  assign arready = read_grant;

  // Payload, loaded on the handshake edge
  always_ff @(posedge clk) begin
    if (any_grant) begin
      addr_q  <= write_grant ? awaddr : araddr;
      prot_q  <= write_grant ? awprot : arprot;
      wdata_q <= wdata;
      strb_q  <= wstrb;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      write_q <= 1'b0;
    end else if (any_grant) begin
      write_q <= write_grant;
    end
  end

  // ------------------------------
  // Execute: APB master FSM
  // ------------------------------
  assign access_done = (state_q == StAccess) && pready;
  assign resp_taken  = write_q ? bready : rready;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StIdle:   if (any_grant) state_d = StSetup;
      StSetup:  state_d = StAccess;
      StAccess: if (pready) state_d = StResp;
      StResp:   if (resp_taken) state_d = StIdle;
      default:  state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // psel covers setup and access only
  assign psel    = (state_q == StSetup) || (state_q == StAccess);
  assign penable = (state_q == StAccess);
  assign paddr   = addr_q;
  assign pwrite  = write_q;
  assign pwdata  = wdata_q;
  assign pstrb   = strb_q;
  assign pprot   = prot_q;

  // ------------------------------
  // Result: B and R channels
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slverr_q <= 1'b0;
    end else if (access_done) begin
      slverr_q <= pslverr;
    end
  end

  // Read data held for the R channel
  always_ff @(posedge clk) begin
    if (access_done) begin
      rdata <= prdata;
    end
  end

  assign bvalid = (state_q == StResp) && write_q;
  assign rvalid = (state_q == StResp) && !write_q;
  assign bresp  = slverr_q ? RespSlverr : RespOkay;
  assign rresp  = slverr_q ? RespSlverr : RespOkay;

  // ------------------------------
  // Checks
  // ------------------------------
  state_known_a : assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(state_d)
  );

  // Request fields hold until the access completes
  apb_stable_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    psel && !(penable && pready)
    |=> psel && $stable({paddr, pwrite, pwdata, pstrb, pprot})
  );

  resp_exclusive_a : assert property (
    @(posedge clk) disable iff (!rst_n) !(bvalid && rvalid)
  );

endmodule

`default_nettype wire

// File: common/amba_pkg.sv
/* Widths, response codes and address map shared by the bridge and the APB side.
   Only address bits 13:12 pick a region; regions 2 and 3 have no peripheral. */
`default_nettype none

package amba_pkg;

  // ------------------------------
  // Field widths
  // ------------------------------
  localparam int AxiProtWidth = 3;
  localparam int ApbProtWidth = 3;
  localparam int AxiRespWidth = 2;

  // Bit 0 set means a privileged access
  typedef logic [AxiProtWidth-1:0] prot_t;
  typedef logic [AxiRespWidth-1:0] axi_resp_t;

  // Response codes on bresp and rresp
  localparam axi_resp_t RespOkay = 2'd0;
  localparam axi_resp_t RespSlverr = 2'd2;

  // ------------------------------
  // Address map
  // ------------------------------
  localparam int RegionLsb = 12;
  localparam int RegionWidth = 2;

  typedef logic [RegionWidth-1:0] region_t;

  localparam region_t RegionRegfile = 2'd0;
  localparam region_t RegionScratch = 2'd1;

  // Bridge FSM states, one-hot
  typedef enum logic [3:0] {
    StIdle   = 4'b0001,
    StSetup  = 4'b0010,
    StAccess = 4'b0100,
    StResp   = 4'b1000
  } bridge_state_t;

endpackage

`default_nettype wire

// File: list.f
common/amba_pkg.sv
src/rr_arbiter.sv
axil2apb/axil2apb_bridge.sv
src/apb_decoder.sv
src/apb_regfile.sv
src/apb_scratch_ram.sv
src/axil_apb_top.sv
sim/tb_top.sv

// File: sim/tb_top.sv
/* Random AXI4-Lite master against a reference model of the register file and scratch RAM.
   Expects the DUT default parameters; the first mismatch or timeout ends the run. */
`default_nettype none

module tb_top;

  import amba_pkg::*;

  localparam int AddrWidth  = 16;
  localparam int DataWidth  = 32;
  localparam int WaitCycles = 2;
  localparam int NumTrans   = 400;
  localparam int Timeout    = 50;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;

  logic                   clk;
  logic                   rst_n;
  logic [AddrWidth-1:0]   awaddr;
  prot_t                  awprot;
  logic                   awvalid;
  logic                   awready;
  logic [DataWidth-1:0]   wdata;
  logic [DataWidth/8-1:0] wstrb;
  logic                   wvalid;
  logic                   wready;
  axi_resp_t              bresp;
  logic                   bvalid;
  logic                   bready;
  logic [AddrWidth-1:0]   araddr;
  prot_t                  arprot;
  logic                   arvalid;
  logic                   arready;
  logic [DataWidth-1:0]   rdata;
  axi_resp_t              rresp;
  logic                   rvalid;
  logic                   rready;

  // Model state
  logic [31:0] lfsr_q;
  logic [31:0] reg_model [8];
  logic [31:0] ram_model [16];
  // Arbiter pointer as seen from outside with the read side favored after reset
  logic        fav_write;
  int          write_first_count;
  int          read_first_count;

  axil_apb_top #(
    .AddrWidth  (AddrWidth),
    .DataWidth  (DataWidth),
    .WaitCycles (WaitCycles)
  ) axil_apb_top_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awprot  (awprot),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arprot  (arprot),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------
  // Random bits and reporting
  // ------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LfsrTaps;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_readies_low();
    check_value("awready", awready, 1'b0);
    check_value("wready", wready, 1'b0);
    check_value("arready", arready, 1'b0);
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic model_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic priv,
                             output axi_resp_t resp);
    resp = RespSlverr;
    case (addr[13:12])
      2'd0: begin
        reg_model[addr[4:2]] = merge_bytes(reg_model[addr[4:2]], data, strb);
        resp = RespOkay;
      end
      2'd1: begin
        // Unprivileged RAM writes are dropped
        if (priv) begin
          ram_model[addr[5:2]] = merge_bytes(ram_model[addr[5:2]], data, strb);
          resp = RespOkay;
        end
      end
      default: resp = RespSlverr;
    endcase
  endtask

  task automatic model_read(input logic [15:0] addr, output logic [31:0] data,
                            output axi_resp_t resp);
    data = '0;
    resp = RespSlverr;
    case (addr[13:12])
      2'd0: begin
        data = reg_model[addr[4:2]];
        resp = RespOkay;
      end
      2'd1: begin
        data = ram_model[addr[5:2]];
        resp = RespOkay;
      end
      default: resp = RespSlverr;
    endcase
  endtask

  // Handshake cycle to first valid cycle
  function automatic int expected_latency(input logic [15:0] addr);
    return (addr[13:12] == 2'd1) ? 3 + WaitCycles : 3;
  endfunction

  // ------------------------------
  // AXI master
  // ------------------------------
  task automatic await_grant(input logic is_write);
    int cycles;
    cycles = 0;
    while (1'b1) begin
      @(negedge clk);
      if (is_write ? awready : arready) break;
      check_readies_low();
      cycles++;
      if (cycles >= Timeout) abort_run(is_write ? "Timed out waiting for awready"
                                                : "Timed out waiting for arready");
    end
    if (is_write) begin
      check_value("wready", wready, 1'b1);
      check_value("arready", arready, 1'b0);
    end else begin
      check_value("awready", awready, 1'b0);
      check_value("wready", wready, 1'b0);
    end
    // Winner loses priority for the next tie
    fav_write = !is_write;
    @(posedge clk);
    #2;
  endtask

  task automatic check_response(input logic is_write, input axi_resp_t exp_resp,
                                input logic [31:0] exp_data);
    if (is_write) begin
      check_value("bvalid", bvalid, 1'b1);
      check_value("rvalid", rvalid, 1'b0);
      check_value("bresp", bresp, exp_resp);
    end else begin
      check_value("rvalid", rvalid, 1'b1);
      check_value("bvalid", bvalid, 1'b0);
      check_value("rresp", rresp, exp_resp);
      check_value("rdata", rdata, exp_data);
    end
    check_readies_low();
  endtask

  // Delay 0 keeps ready high before valid arrives
  task automatic await_response(input logic is_write, input axi_resp_t exp_resp,
                                input logic [31:0] exp_data, input int exp_lat,
                                input int delay);
    int lat;
    lat = 0;
    if (delay == 0) begin
      bready = is_write;
      rready = !is_write;
    end
    while (1'b1) begin
      @(negedge clk);
      lat++;
      if (is_write ? bvalid : rvalid) break;
      check_readies_low();
      if (lat >= Timeout) abort_run("Timed out waiting for a response valid");
    end
    check_value("latency", lat, exp_lat);
    check_response(is_write, exp_resp, exp_data);
    for (int i = 1; i <= delay; i++) begin
      @(posedge clk);
      #2;
      if (i == delay) begin
        bready = is_write;
        rready = !is_write;
      end
      @(negedge clk);
      check_response(is_write, exp_resp, exp_data);
    end
    @(posedge clk);
    #2;
    bready = 1'b0;
    rready = 1'b0;
  endtask

  task automatic run_write(input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic priv,
                           input logic together, input logic lead_aw, input int delay);
    axi_resp_t exp_resp;
    model_write(addr, data, strb, priv, exp_resp);
    awaddr = addr;
    awprot = {2'b00, priv};
    wdata  = data;
    wstrb  = strb;
    if (!together) begin
      // Half a write must not be taken
      awvalid = lead_aw;
      wvalid  = !lead_aw;
      @(negedge clk);
      check_readies_low();
      @(posedge clk);
      #2;
    end
    awvalid = 1'b1;
    wvalid  = 1'b1;
    await_grant(1'b1);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    await_response(1'b1, exp_resp, '0, expected_latency(addr), delay);
  endtask

  task automatic run_read(input logic [15:0] addr, input logic priv, input int delay);
    axi_resp_t   exp_resp;
    logic [31:0] exp_data;
    model_read(addr, exp_data, exp_resp);
    araddr  = addr;
    arprot  = {2'b00, priv};
    arvalid = 1'b1;
    await_grant(1'b0);
    arvalid = 1'b0;
    await_response(1'b0, exp_resp, exp_data, expected_latency(addr), delay);
  endtask

  // Write and read to one address in the same idle cycle
  task automatic run_dual(input logic [15:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input logic priv,
                          input int delay_w, input int delay_r);
    logic        write_first;
    axi_resp_t   b_exp;
    axi_resp_t   r_exp;
    logic [31:0] r_data;
    write_first = fav_write;
    if (write_first) begin
      model_write(addr, data, strb, priv, b_exp);
      model_read(addr, r_data, r_exp);
      write_first_count++;
    end else begin
      model_read(addr, r_data, r_exp);
      model_write(addr, data, strb, priv, b_exp);
      read_first_count++;
    end
    awaddr  = addr;
    awprot  = {2'b00, priv};
    wdata   = data;
    wstrb   = strb;
    araddr  = addr;
    arprot  = {2'b00, priv};
    awvalid = 1'b1;
    wvalid  = 1'b1;
    arvalid = 1'b1;
    if (write_first) begin
      await_grant(1'b1);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      await_response(1'b1, b_exp, '0, expected_latency(addr), delay_w);
      await_grant(1'b0);
      arvalid = 1'b0;
      await_response(1'b0, r_exp, r_data, expected_latency(addr), delay_r);
    end else begin
      await_grant(1'b0);
      arvalid = 1'b0;
      await_response(1'b0, r_exp, r_data, expected_latency(addr), delay_r);
      await_grant(1'b1);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      await_response(1'b1, b_exp, '0, expected_latency(addr), delay_w);
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    logic [2:0]  mode;
    logic        is_write;
    logic [1:0]  region;
    logic [5:0]  offset;
    logic [31:0] data;
    logic [3:0]  strb;
    logic        priv;
    logic        together;
    logic        lead_aw;
    int          delay_a;
    int          delay_b;
    logic [15:0] addr;

    lfsr_q            = 32'h315b;
    fav_write         = 1'b0;
    write_first_count = 0;
    read_first_count  = 0;
    for (int i = 0; i < 8; i++) begin
      reg_model[i] = '0;
    end
    for (int i = 0; i < 16; i++) begin
      ram_model[i] = '0;
    end

    rst_n   = 1'b0;
    awaddr  = '0;
    awprot  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arprot  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;

    // Three rising edges under reset
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_readies_low();
    check_value("bvalid", bvalid, 1'b0);
    check_value("rvalid", rvalid, 1'b0);
    check_value("psel", axil_apb_top_inst.psel, 1'b0);
    check_value("penable", axil_apb_top_inst.penable, 1'b0);
    @(posedge clk);
    #2;
    rst_n = 1'b1;

    for (int t = 0; t < NumTrans; t++) begin
      mode     = take_bits(3);
      is_write = take_bits(1);
      region   = take_bits(2);
      offset   = take_bits(6);
      data     = take_bits(32);
      strb     = take_bits(4);
      priv     = take_bits(1);
      together = take_bits(1);
      lead_aw  = take_bits(1);
      delay_a  = int'(take_bits(2));
      delay_b  = int'(take_bits(2));
      // Offset bits above the index alias
      addr = {2'b00, region, 4'h0, offset, 2'b00};
      if (mode == 3'd0) begin
        run_dual(addr, data, strb, priv, delay_a, delay_b);
      end else if (is_write) begin
        run_write(addr, data, strb, priv, together, lead_aw, delay_a);
      end else begin
        run_read(addr, priv, delay_a);
      end
    end

    if (write_first_count == 0 || read_first_count == 0) begin
      abort_run("Simultaneous requests did not see both grant orders");
    end else begin
      $display("TEST PASS");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/apb_decoder.sv
/* Region decode on paddr[13:12]; needs AddrWidth of at least 14.
   Unmapped regions complete at once with pslverr and zero read data. */
`default_nettype none

module apb_decoder #(
  parameter int AddrWidth = 16,
  parameter int DataWidth = 32
) (
  input  logic [AddrWidth-1:0] paddr,
  input  logic                 psel,
  input  logic                 penable,
  output logic [DataWidth-1:0] prdata,
  output logic                 pready,
  output logic                 pslverr,

  // Per-peripheral selects
  output logic                 sel_regfile,
  output logic                 sel_scratch,

  // Per-peripheral returns
  input  logic [DataWidth-1:0] rdata_regfile,
  input  logic                 ready_regfile,
  input  logic                 slverr_regfile,
  input  logic [DataWidth-1:0] rdata_scratch,
  input  logic                 ready_scratch,
  input  logic                 slverr_scratch
);

  import amba_pkg::*;

  region_t region;

  if (AddrWidth < RegionLsb + RegionWidth) begin : gen_bad_addr_width
    $error("AddrWidth too small for the region field");
  end

  assign region = paddr[RegionLsb +: RegionWidth];

  // Only the addressed peripheral sees psel
  assign sel_regfile = psel && (region == RegionRegfile);
  assign sel_scratch = psel && (region == RegionScratch);

  // ------------------------------
  // Return path
  // ------------------------------
  always_comb begin
    case (region)
      RegionRegfile: begin
        prdata  = rdata_regfile;
        pready  = ready_regfile;
        pslverr = slverr_regfile;
      end
      RegionScratch: begin
        prdata  = rdata_scratch;
        pready  = ready_scratch;
        pslverr = slverr_scratch;
      end
      default: begin
        // Nothing mapped here so the error comes back in the access phase
        prdata  = '0;
        pready  = 1'b1;
        pslverr = psel && penable;
      end
    endcase
  end

  // At most one peripheral selected
  always_comb begin
    sel_exclusive_a : assert #0 (!(sel_regfile && sel_scratch));
  end

endmodule

`default_nettype wire

// File: src/apb_regfile.sv
/* Eight registers on paddr[4:2]; higher offset bits alias. No wait states.
   Writes honor pstrb per byte; slverr is never raised. */
`default_nettype none

module apb_regfile #(
  parameter int AddrWidth = 16,
  parameter int DataWidth = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [AddrWidth-1:0]   paddr,
  input  logic [DataWidth-1:0]   pwdata,
  input  logic [DataWidth/8-1:0] pstrb,
  output logic [DataWidth-1:0]   rdata,
  output logic                   ready,
  output logic                   slverr
);

  localparam int NumRegs = 8;
  localparam int IdxWidth = 3;
  localparam int StrbWidth = DataWidth / 8;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [IdxWidth-1:0] idx_t;

  data_t regs [NumRegs];
  idx_t  idx;
  logic  wr_en;

  // Word index, byte offset dropped
  assign idx = paddr[2 +: IdxWidth];

  // Completes in the first access cycle
  assign ready  = sel && penable;
  assign slverr = 1'b0;
  assign wr_en  = ready && pwrite;

  // ------------------------------
  // Register array
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      // Merge only the strobed bytes
      for (int b = 0; b < StrbWidth; b++) begin
        if (pstrb[b]) begin
          regs[idx][8*b +: 8] <= pwdata[8*b +: 8];
        end
      end
    end
  end

  // Read is a plain mux
  assign rdata = regs[idx];

  // Selected without penable means setup, no write there
  write_in_access_a : assert property (
    @(posedge clk) disable iff (!rst_n) wr_en |-> $past(sel)
  );

endmodule

`default_nettype wire

// File: src/apb_scratch_ram.sv
/* Sixteen words on paddr[5:2], WaitCycles from 0 to 7 before ready.
   Unprivileged writes (pprot[0] low) get slverr and change nothing. */
`default_nettype none

module apb_scratch_ram #(
  parameter int AddrWidth  = 16,
  parameter int DataWidth  = 32,
  parameter int WaitCycles = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [AddrWidth-1:0]   paddr,
  input  logic [DataWidth-1:0]   pwdata,
  input  logic [DataWidth/8-1:0] pstrb,
  input  amba_pkg::prot_t        pprot,
  output logic [DataWidth-1:0]   rdata,
  output logic                   ready,
  output logic                   slverr
);

  localparam int NumWords = 16;
  localparam int IdxWidth = 4;
  localparam int CntWidth = 3;
  localparam int StrbWidth = DataWidth / 8;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [IdxWidth-1:0] idx_t;
  typedef logic [CntWidth-1:0] cnt_t;

  data_t mem [NumWords];
  idx_t  idx;
  cnt_t  cnt_q;
  logic  in_access;
  logic  wr_en;

  if (WaitCycles < 0 || WaitCycles > 7) begin : gen_bad_wait
    $error("WaitCycles must lie in 0..7");
  end

  assign idx       = paddr[2 +: IdxWidth];
  assign in_access = sel && penable;

  // ------------------------------
  // Wait-state counter
  // ------------------------------
  // Counts access cycles, ready once WaitCycles have gone by
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (ready) begin
      cnt_q <= '0;
    end else if (in_access) begin
      cnt_q <= cnt_q + cnt_t'(1);
    end
  end

  assign ready = in_access && (cnt_q == cnt_t'(WaitCycles));

  // Privilege check on the completing cycle
  assign slverr = ready && pwrite && !pprot[0];
  assign wr_en  = ready && pwrite && pprot[0];

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NumWords; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (pstrb[b]) begin
          mem[idx][8*b +: 8] <= pwdata[8*b +: 8];
        end
      end
    end
  end

  // Reads always succeed, sampled by the master on ready
  assign rdata = mem[idx];

  wait_bound_a : assert property (
    @(posedge clk) disable iff (!rst_n) cnt_q <= cnt_t'(WaitCycles)
  );

endmodule

`default_nettype wire

// File: src/axil_apb_top.sv
/* AXI4-Lite slave into an APB bus with a register file and a scratch RAM.
   AddrWidth at least 14, DataWidth a multiple of 8, WaitCycles 0 to 7. */
`default_nettype none

module axil_apb_top #(
  parameter int AddrWidth  = 16,
  parameter int DataWidth  = 32,
  parameter int WaitCycles = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // AXI4-Lite slave
  input  logic [AddrWidth-1:0]   awaddr,
  input  amba_pkg::prot_t        awprot,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [DataWidth-1:0]   wdata,
  input  logic [DataWidth/8-1:0] wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output amba_pkg::axi_resp_t    bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [AddrWidth-1:0]   araddr,
  input  amba_pkg::prot_t        arprot,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [DataWidth-1:0]   rdata,
  output amba_pkg::axi_resp_t    rresp,
  output logic                   rvalid,
  input  logic                   rready
);

  import amba_pkg::*;

  // ------------------------------
  // APB bus
  // ------------------------------
  logic [AddrWidth-1:0]   paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [DataWidth-1:0]   pwdata;
  logic [DataWidth/8-1:0] pstrb;
  prot_t                  pprot;
  logic [DataWidth-1:0]   prdata;
  logic                   pready;
  logic                   pslverr;

  // Peripheral side of the decoder
  logic                   sel_regfile;
  logic                   sel_scratch;
  logic [DataWidth-1:0]   rdata_regfile;
  logic                   ready_regfile;
  logic                   slverr_regfile;
  logic [DataWidth-1:0]   rdata_scratch;
  logic                   ready_scratch;
  logic                   slverr_scratch;

  axil2apb_bridge #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth)
  ) axil2apb_bridge_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awprot  (awprot),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arprot  (arprot),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .pprot   (pprot),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  apb_decoder #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth)
  ) apb_decoder_inst (
    .paddr          (paddr),
    .psel           (psel),
    .penable        (penable),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .sel_regfile    (sel_regfile),
    .sel_scratch    (sel_scratch),
    .rdata_regfile  (rdata_regfile),
    .ready_regfile  (ready_regfile),
    .slverr_regfile (slverr_regfile),
    .rdata_scratch  (rdata_scratch),
    .ready_scratch  (ready_scratch),
    .slverr_scratch (slverr_scratch)
  );

  // Region 0
  apb_regfile #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth)
  ) apb_regfile_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .sel     (sel_regfile),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .rdata   (rdata_regfile),
    .ready   (ready_regfile),
    .slverr  (slverr_regfile)
  );

  // Region 1, slow and privileged writes only
  apb_scratch_ram #(
    .AddrWidth  (AddrWidth),
    .DataWidth  (DataWidth),
    .WaitCycles (WaitCycles)
  ) apb_scratch_ram_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .sel     (sel_scratch),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .pprot   (pprot),
    .rdata   (rdata_scratch),
    .ready   (ready_scratch),
    .slverr  (slverr_scratch)
  );

endmodule

`default_nettype wire

// File: src/rr_arbiter.sv
/* Two-way round-robin arbiter with a purely combinational grant.
   The priority moves only on a cycle that grants someone. */
`default_nettype none

module rr_arbiter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [1:0] request,
  output logic [1:0] grant
);

  // Index of the requester that wins a tie
  logic prio_q;

  always_comb begin
    grant = 2'b00;
    if (request[prio_q]) begin
      grant[prio_q] = 1'b1;
    end else if (request[~prio_q]) begin
      grant[~prio_q] = 1'b1;
    end
  end

  // Winner 0 hands priority to 1, and the other way round
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_q <= 1'b0;
    end else if (|grant) begin
      prio_q <= grant[0];
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  grant_onehot_a : assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(grant)
  );

endmodule

`default_nettype wire
